// ==== include/apu_settings.svh ====
// --------------------------------------------------------------------
// Widths, depths and address map of the sound subsystem
// --------------------------------------------------------------------

`ifndef APU_SETTINGS_SVH
`define APU_SETTINGS_SVH

// Internal bus
`define APU_ADDR_W      16
`define APU_DATA_W      32

// Local word RAM
`define APU_RAM_DEPTH   512

// Audio path
`define APU_SAMPLE_W    16
`define APU_FIFO_AW     2
`define APU_PWM_W       8

// Peripheral pages, decoded through the page mask
`define APU_TIMER_BASE  16'hA000
`define APU_AOUT_BASE   16'h9000
`define APU_PAGE_MASK   16'hF000

`endif

// ==== source/apu_pkg.sv ====
// --------------------------------------------------------------------
// Shared types: AHB transfer type, register offsets, player state
// --------------------------------------------------------------------

package apu_pkg;

    // AHB-Lite HTRANS encoding
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // Timer byte offsets within its page
    typedef enum logic [4:0] {
        TIMER_CTRL  = 5'h00,
        TIMER_CMP   = 5'h04,
        TIMER_COUNT = 5'h08
    } timer_reg_e;

    // Audio output byte offsets within its page
    typedef enum logic [4:0] {
        AOUT_CSR      = 5'h00,
        AOUT_INTERVAL = 5'h04,
        AOUT_IRQLEVEL = 5'h08,
        AOUT_FIFO     = 5'h0C,
        AOUT_STATUS   = 5'h10
    } aout_reg_e;

    typedef enum logic {
        AOUT_IDLE = 1'b0,
        AOUT_PLAY = 1'b1
    } aout_state_e;

endpackage

// ==== source/apu_bus_if.sv ====
// --------------------------------------------------------------------
// Decoded internal register bus between decoder and peripherals
// --------------------------------------------------------------------

`include "apu_settings.svh"

interface apu_bus_if;

    logic                   stb;
    logic                   write;
    logic [`APU_ADDR_W-1:0] addr;
    logic [`APU_DATA_W-1:0] wdata;
    logic [`APU_DATA_W-1:0] rdata;

    // Decoder side
    modport ctrl (output stb, output write, output addr, output wdata, input rdata);

    // Peripheral side, rdata is registered and held until the next stb
    modport periph (input stb, input write, input addr, input wdata, output rdata);

endinterface

// ==== source/apu_bus_decoder.sv ====
// --------------------------------------------------------------------
// AHB-Lite slave port with address decode onto three internal buses
// --------------------------------------------------------------------

`include "apu_settings.svh"

module apu_bus_decoder (
    input  logic                   clk_sys,
    input  logic                   rst_n_sys,
    input  logic [`APU_ADDR_W-1:0] haddr,
    input  logic                   hwrite,
    input  apu_pkg::htrans_e       htrans,
    input  logic                   hready,
    input  logic [`APU_DATA_W-1:0] hwdata,
    output logic                   hready_resp,
    output logic                   hresp,
    output logic [`APU_DATA_W-1:0] hrdata,
    apu_bus_if.ctrl                ram_bus,
    apu_bus_if.ctrl                timer_bus,
    apu_bus_if.ctrl                aout_bus
);

    logic                   accept;
    logic                   hit_ram;
    logic                   hit_timer;
    logic                   hit_aout;
    logic                   busy_q;
    logic                   err_q;
    logic                   sel_ram_q;
    logic                   sel_timer_q;
    logic                   sel_aout_q;
    logic [`APU_ADDR_W-1:0] addr_q;
    logic                   write_q;

    assign accept = hready && (htrans == apu_pkg::HTRANS_NONSEQ ||
                               htrans == apu_pkg::HTRANS_SEQ);

    // RAM in the lower half, 4k peripheral pages above
    assign hit_ram   = !haddr[`APU_ADDR_W-1];
    assign hit_timer = (haddr & `APU_PAGE_MASK) == `APU_TIMER_BASE;
    assign hit_aout  = (haddr & `APU_PAGE_MASK) == `APU_AOUT_BASE;

    // ----------------------------------------------------------------
    // Data phase control
    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            busy_q      <= 1'b0;
            err_q       <= 1'b0;
            sel_ram_q   <= 1'b0;
            sel_timer_q <= 1'b0;
            sel_aout_q  <= 1'b0;
        end else if (accept) begin
            busy_q      <= 1'b1;
            err_q       <= !(hit_ram || hit_timer || hit_aout);
            sel_ram_q   <= hit_ram;
            sel_timer_q <= hit_timer;
            sel_aout_q  <= hit_aout;
        end else begin
            busy_q <= 1'b0;
            // Error stays up through the second data cycle
            if (!busy_q)
                err_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            addr_q  <= haddr;
            write_q <= hwrite;
        end
    end

    // One wait state, then OKAY or the second ERROR cycle
    assign hready_resp = !busy_q;
    assign hresp       = err_q;

    // ----------------------------------------------------------------
    // Internal buses, write data comes straight from the data phase
    assign ram_bus.stb     = busy_q && sel_ram_q;
    assign ram_bus.write   = write_q;
    assign ram_bus.addr    = addr_q;
    assign ram_bus.wdata   = hwdata;

    assign timer_bus.stb   = busy_q && sel_timer_q;
    assign timer_bus.write = write_q;
    assign timer_bus.addr  = addr_q;
    assign timer_bus.wdata = hwdata;

    assign aout_bus.stb    = busy_q && sel_aout_q;
    assign aout_bus.write  = write_q;
    assign aout_bus.addr   = addr_q;
    assign aout_bus.wdata  = hwdata;

    always_comb begin
        if (sel_ram_q)
            hrdata = ram_bus.rdata;
        else if (sel_timer_q)
            hrdata = timer_bus.rdata;
        else if (sel_aout_q)
            hrdata = aout_bus.rdata;
        else
            hrdata = '0;
    end

endmodule

// ==== source/apu_ram.sv ====
// --------------------------------------------------------------------
// Local word RAM with registered read
// --------------------------------------------------------------------

`include "apu_settings.svh"

module apu_ram (
    input  logic       clk_sys,
    input  logic       rst_n_sys,
    apu_bus_if.periph  bus
);

    localparam int RAM_AW = $clog2(`APU_RAM_DEPTH);

    logic [`APU_DATA_W-1:0] mem [0:`APU_RAM_DEPTH-1];
    logic [RAM_AW-1:0]      index;

    // Word index, upper address bits alias
    assign index = bus.addr[RAM_AW+1:2];

    always_ff @(posedge clk_sys) begin
        if (bus.stb && bus.write)
            mem[index] <= bus.wdata;
    end

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            bus.rdata <= '0;
        end else if (bus.stb && !bus.write) begin
            bus.rdata <= mem[index];
        end
    end

endmodule

// ==== source/apu_timer.sv ====
// --------------------------------------------------------------------
// Free-running timer with compare interrupt
// --------------------------------------------------------------------

`include "apu_settings.svh"

module apu_timer (
    input  logic       clk_sys,
    input  logic       rst_n_sys,
    apu_bus_if.periph  bus,
    output logic       irq
);

    logic                   wr;
    logic                   enable_q;
    logic [`APU_DATA_W-1:0] cmp_q;
    logic [`APU_DATA_W-1:0] count_q;

    assign wr = bus.stb && bus.write;

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            enable_q <= 1'b0;
            cmp_q    <= '0;
            count_q  <= '0;
            irq      <= 1'b0;
        end else begin
            if (wr && bus.addr[4:0] == apu_pkg::TIMER_CTRL)
                enable_q <= bus.wdata[0];
            if (wr && bus.addr[4:0] == apu_pkg::TIMER_CMP)
                cmp_q <= bus.wdata;
            // A bus load wins over counting
            if (wr && bus.addr[4:0] == apu_pkg::TIMER_COUNT)
                count_q <= bus.wdata;
            else if (enable_q)
                count_q <= count_q + 1'b1;
            irq <= enable_q && (count_q >= cmp_q);
        end
    end

    // Read data
    always_ff @(posedge clk_sys) begin
        if (bus.stb && !bus.write) begin
            case (bus.addr[4:0])
                apu_pkg::TIMER_CTRL:  bus.rdata <= {{(`APU_DATA_W-1){1'b0}}, enable_q};
                apu_pkg::TIMER_CMP:   bus.rdata <= cmp_q;
                apu_pkg::TIMER_COUNT: bus.rdata <= count_q;
                default:              bus.rdata <= '0;
            endcase
        end
    end

endmodule

// ==== source/apu_aout_regs.sv ====
// --------------------------------------------------------------------
// Audio output control and status registers, sample write port
// --------------------------------------------------------------------

`include "apu_settings.svh"

module apu_aout_regs (
    input  logic                     clk_sys,
    input  logic                     rst_n_sys,
    apu_bus_if.periph                bus,
    input  logic [`APU_FIFO_AW:0]    level,
    output logic                     push,
    output logic [`APU_SAMPLE_W-1:0] push_data,
    output logic                     enable,
    output logic [7:0]               interval,
    output logic                     irq
);

    localparam int FIFO_DEPTH = 1 << `APU_FIFO_AW;

    logic                  wr;
    logic                  full;
    logic                  signed_q;
    logic [`APU_FIFO_AW:0] irqlevel_q;

    assign wr   = bus.stb && bus.write;
    assign full = level == FIFO_DEPTH[`APU_FIFO_AW:0];

    // ----------------------------------------------------------------
    // Sample port, writes to a full FIFO are dropped
    assign push = wr && bus.addr[4:0] == apu_pkg::AOUT_FIFO && !full;

    // Signed samples become offset binary for the PWM
    assign push_data = {bus.wdata[`APU_SAMPLE_W-1] ^ signed_q,
                        bus.wdata[`APU_SAMPLE_W-2:0]};

    assign irq = level <= irqlevel_q;

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            enable     <= 1'b0;
            signed_q   <= 1'b0;
            interval   <= '0;
            irqlevel_q <= '0;
        end else if (wr) begin
            case (bus.addr[4:0])
                apu_pkg::AOUT_CSR: begin
                    enable   <= bus.wdata[0];
                    signed_q <= bus.wdata[1];
                end
                apu_pkg::AOUT_INTERVAL: interval   <= bus.wdata[7:0];
                apu_pkg::AOUT_IRQLEVEL: irqlevel_q <= bus.wdata[`APU_FIFO_AW:0];
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------------
    // Read data, running tracks enable on a single clock
    always_ff @(posedge clk_sys) begin
        if (bus.stb && !bus.write) begin
            bus.rdata <= '0;
            case (bus.addr[4:0])
                apu_pkg::AOUT_CSR:      bus.rdata[2:0] <= {enable, signed_q, enable};
                apu_pkg::AOUT_INTERVAL: bus.rdata[7:0] <= interval;
                apu_pkg::AOUT_IRQLEVEL: bus.rdata[`APU_FIFO_AW:0] <= irqlevel_q;
                apu_pkg::AOUT_STATUS:   bus.rdata[3:0] <= {!full, level};
                default: ;
            endcase
        end
    end

endmodule

// ==== source/apu_sample_fifo.sv ====
// --------------------------------------------------------------------
// Synchronous sample FIFO with fill level
// --------------------------------------------------------------------

`include "apu_settings.svh"

module apu_sample_fifo (
    input  logic                     clk_sys,
    input  logic                     rst_n_sys,
    input  logic                     push,
    input  logic [`APU_SAMPLE_W-1:0] push_data,
    input  logic                     pop,
    output logic [`APU_SAMPLE_W-1:0] pop_data,
    output logic                     empty,
    output logic [`APU_FIFO_AW:0]    level
);

    localparam int DEPTH = 1 << `APU_FIFO_AW;

    logic [`APU_SAMPLE_W-1:0] mem [0:DEPTH-1];
    logic [`APU_FIFO_AW:0]    wptr_q;
    logic [`APU_FIFO_AW:0]    rptr_q;
    logic                     full;

    // Extra pointer bit tells full from empty
    assign empty = wptr_q == rptr_q;
    assign full  = (wptr_q ^ rptr_q) == {1'b1, {`APU_FIFO_AW{1'b0}}};
    assign level = wptr_q - rptr_q;

    assign pop_data = mem[rptr_q[`APU_FIFO_AW-1:0]];

    always_ff @(posedge clk_sys) begin
        if (push && !full)
            mem[wptr_q[`APU_FIFO_AW-1:0]] <= push_data;
    end

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else begin
            if (push && !full)
                wptr_q <= wptr_q + 1'b1;
            if (pop && !empty)
                rptr_q <= rptr_q + 1'b1;
        end
    end

endmodule

// ==== source/apu_aout.sv ====
// --------------------------------------------------------------------
// PWM audio player fed from the sample FIFO
// --------------------------------------------------------------------

`include "apu_settings.svh"

module apu_aout (
    input  logic                     clk_sys,
    input  logic                     rst_n_sys,
    input  logic                     enable,
    input  logic [7:0]               interval,
    input  logic                     empty,
    input  logic [`APU_SAMPLE_W-1:0] pop_data,
    output logic                     pop,
    output logic                     audio
);

    apu_pkg::aout_state_e     state_q;
    logic [`APU_PWM_W-1:0]    phase_q;
    logic [7:0]               rpt_q;
    logic [`APU_SAMPLE_W-1:0] sample_q;
    logic                     period_end;
    logic                     last_rpt;

    assign period_end = &phase_q;
    assign last_rpt   = rpt_q == interval;

    // Fetch on start, then after the last repeat of each sample
    assign pop = enable && !empty &&
                 (state_q == apu_pkg::AOUT_IDLE || (period_end && last_rpt));

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            state_q <= apu_pkg::AOUT_IDLE;
            phase_q <= '0;
            rpt_q   <= '0;
        end else if (!enable) begin
            state_q <= apu_pkg::AOUT_IDLE;
            phase_q <= '0;
            rpt_q   <= '0;
        end else if (state_q == apu_pkg::AOUT_IDLE) begin
            if (!empty)
                state_q <= apu_pkg::AOUT_PLAY;
        end else begin
            phase_q <= phase_q + 1'b1;
            if (period_end)
                rpt_q <= last_rpt ? 8'd0 : rpt_q + 8'd1;
        end
    end

    // Held sample, repeated if the FIFO runs dry
    always_ff @(posedge clk_sys) begin
        if (pop)
            sample_q <= pop_data;
    end

    assign audio = (state_q == apu_pkg::AOUT_PLAY) &&
                   (phase_q < sample_q[`APU_SAMPLE_W-1 -: `APU_PWM_W]);

endmodule

// ==== source/audio_processor.sv ====
// --------------------------------------------------------------------
// Sound subsystem top: AHB-Lite port, RAM, timer and audio path
// --------------------------------------------------------------------

`include "apu_settings.svh"

module audio_processor (
    input  logic                   clk_sys,
    input  logic                   rst_n_sys,
    input  logic [`APU_ADDR_W-1:0] haddr,
    input  logic                   hwrite,
    input  apu_pkg::htrans_e       htrans,
    input  logic                   hready,
    input  logic [`APU_DATA_W-1:0] hwdata,
    output logic                   hready_resp,
    output logic                   hresp,
    output logic [`APU_DATA_W-1:0] hrdata,
    output logic                   irq_timer,
    output logic                   irq_aout,
    output logic                   audio
);

    logic                     fifo_push;
    logic [`APU_SAMPLE_W-1:0] fifo_push_data;
    logic [`APU_FIFO_AW:0]    fifo_level;
    logic                     fifo_pop;
    logic [`APU_SAMPLE_W-1:0] fifo_pop_data;
    logic                     fifo_empty;
    logic                     aout_enable;
    logic [7:0]               aout_interval;

    apu_bus_if ram_bus ();
    apu_bus_if timer_bus ();
    apu_bus_if aout_bus ();

    // ----------------------------------------------------------------
    // Bus side
    apu_bus_decoder i_apu_bus_decoder (
        .clk_sys     (clk_sys),
        .rst_n_sys   (rst_n_sys),
        .haddr       (haddr),
        .hwrite      (hwrite),
        .htrans      (htrans),
        .hready      (hready),
        .hwdata      (hwdata),
        .hready_resp (hready_resp),
        .hresp       (hresp),
        .hrdata      (hrdata),
        .ram_bus     (ram_bus.ctrl),
        .timer_bus   (timer_bus.ctrl),
        .aout_bus    (aout_bus.ctrl)
    );

    apu_ram i_apu_ram (
        .clk_sys   (clk_sys),
        .rst_n_sys (rst_n_sys),
        .bus       (ram_bus.periph)
    );

    apu_timer i_apu_timer (
        .clk_sys   (clk_sys),
        .rst_n_sys (rst_n_sys),
        .bus       (timer_bus.periph),
        .irq       (irq_timer)
    );

    // ----------------------------------------------------------------
    // Audio path
    apu_aout_regs i_apu_aout_regs (
        .clk_sys   (clk_sys),
        .rst_n_sys (rst_n_sys),
        .bus       (aout_bus.periph),
        .level     (fifo_level),
        .push      (fifo_push),
        .push_data (fifo_push_data),
        .enable    (aout_enable),
        .interval  (aout_interval),
        .irq       (irq_aout)
    );

    apu_sample_fifo i_apu_sample_fifo (
        .clk_sys   (clk_sys),
        .rst_n_sys (rst_n_sys),
        .push      (fifo_push),
        .push_data (fifo_push_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_pop_data),
        .empty     (fifo_empty),
        .level     (fifo_level)
    );

    apu_aout i_apu_aout (
        .clk_sys   (clk_sys),
        .rst_n_sys (rst_n_sys),
        .enable    (aout_enable),
        .interval  (aout_interval),
        .empty     (fifo_empty),
        .pop_data  (fifo_pop_data),
        .pop       (fifo_pop),
        .audio     (audio)
    );

endmodule

// ==== testbench/tb_audio_processor.sv ====
// --------------------------------------------------------------------
// Testbench for the sound subsystem: AHB host tasks, RAM, decode,
// timer and audio path tests, bus protocol assertions, timeout
// --------------------------------------------------------------------

`include "apu_settings.svh"

module tb_audio_processor;

    timeunit 1ns;
    timeprecision 1ps;

    // The whole run takes under 2000 cycles, so this leaves ample margin
    localparam int MAX_CYCLES = 20000;
    localparam int N_RAM      = 16;
    localparam int HS_LIMIT   = 16;

    logic                   clk_sys;
    logic                   rst_n_sys;
    logic [`APU_ADDR_W-1:0] haddr;
    logic                   hwrite;
    apu_pkg::htrans_e       htrans;
    logic                   hready;
    logic [`APU_DATA_W-1:0] hwdata;
    logic                   hready_resp;
    logic                   hresp;
    logic [`APU_DATA_W-1:0] hrdata;
    logic                   irq_timer;
    logic                   irq_aout;
    logic                   audio;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycles       = 0;

    logic [`APU_DATA_W-1:0] ram_model [0:`APU_RAM_DEPTH-1];
    logic [`APU_ADDR_W-1:0] ram_addr [0:N_RAM-1];

    audio_processor i_audio_processor (
        .clk_sys     (clk_sys),
        .rst_n_sys   (rst_n_sys),
        .haddr       (haddr),
        .hwrite      (hwrite),
        .htrans      (htrans),
        .hready      (hready),
        .hwdata      (hwdata),
        .hready_resp (hready_resp),
        .hresp       (hresp),
        .hrdata      (hrdata),
        .irq_timer   (irq_timer),
        .irq_aout    (irq_aout),
        .audio       (audio)
    );

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ----------------------------------------------------------------
    // Bus protocol: one wait state, and an ERROR response of two cycles
    assert property (@(posedge clk_sys) disable iff (!rst_n_sys) !hready_resp |=> hready_resp)
    else begin
        $display("[ERROR] %0t: hready_resp low for more than one cycle", $time);
        errors++;
    end

    assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
                     (hresp && !hready_resp) |=> (hresp && hready_resp))
    else begin
        $display("[ERROR] %0t: ERROR response not held for its second cycle", $time);
        errors++;
    end

    // ----------------------------------------------------------------
    // Helpers
    function automatic logic [`APU_ADDR_W-1:0] timer_addr(input apu_pkg::timer_reg_e r);
        return `APU_TIMER_BASE | {11'd0, r};
    endfunction

    function automatic logic [`APU_ADDR_W-1:0] aout_addr(input apu_pkg::aout_reg_e r);
        return `APU_AOUT_BASE | {11'd0, r};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    // One AHB transfer; returns at the last data cycle with hrdata sampled
    task automatic bus_access(input logic wr, input logic [`APU_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, input logic expect_err,
                              output logic [31:0] rdata);
        int   waits;
        logic first_resp;
        @(posedge clk_sys);
        haddr  <= addr;
        hwrite <= wr;
        htrans <= apu_pkg::HTRANS_NONSEQ;
        @(posedge clk_sys);
        htrans <= apu_pkg::HTRANS_IDLE;
        hwdata <= wdata;
        waits = 0;
        @(negedge clk_sys);
        first_resp = hresp;
        while (!hready_resp && waits < HS_LIMIT) begin
            waits++;
            @(negedge clk_sys);
        end
        rdata = hrdata;
        if (waits >= HS_LIMIT) begin
            $display("Transfer to address 0x%04h never completed", addr);
            errors++;
        end
        check_value("wait states", 32'(waits), 32'd1);
        check_value("hresp in first data cycle", {31'd0, first_resp}, {31'd0, expect_err});
        check_value("hresp in last data cycle", {31'd0, hresp}, {31'd0, expect_err});
    endtask

    task automatic bus_write(input logic [`APU_ADDR_W-1:0] addr, input logic [31:0] wdata);
        logic [31:0] unused_rd;
        bus_access(1'b1, addr, wdata, 1'b0, unused_rd);
    endtask

    task automatic bus_read(input logic [`APU_ADDR_W-1:0] addr, output logic [31:0] rdata);
        bus_access(1'b0, addr, 32'd0, 1'b0, rdata);
    endtask

    task automatic apply_reset();
        @(posedge clk_sys);
        rst_n_sys <= 1'b0;
        repeat (3) @(posedge clk_sys);
        rst_n_sys <= 1'b1;
        @(negedge clk_sys);
        check_value("hready_resp after reset", {31'd0, hready_resp}, 32'd1);
        check_value("hresp after reset", {31'd0, hresp}, 32'd0);
        check_value("irq_timer after reset", {31'd0, irq_timer}, 32'd0);
        check_value("irq_aout after reset", {31'd0, irq_aout}, 32'd1);
        check_value("audio after reset", {31'd0, audio}, 32'd0);
    endtask

    // Waits for audio to rise, then counts high cycles over one PWM period
    task automatic measure_duty(input string what, input int expected);
        int wait_cycles;
        int high;
        wait_cycles = 0;
        high = 0;
        @(negedge clk_sys);
        while (!audio && wait_cycles < 1000) begin
            wait_cycles++;
            @(negedge clk_sys);
        end
        if (!audio) begin
            $display("%s: audio output never went high", what);
            errors++;
        end else begin
            repeat (256) begin
                if (audio)
                    high++;
                @(negedge clk_sys);
            end
            check_value(what, 32'(high), 32'(expected));
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("[ok]   %s", name);
        end else begin
            tests_failed++;
            $display("[fail] %s", name);
        end
    endtask

    // ----------------------------------------------------------------
    // Stimulus
    initial begin
        logic [31:0] rd;
        logic [31:0] data;
        logic [31:0] last_count;
        int          idx;
        int          lvl;
        int          err0;
        int          reads;
        int          high;
        bit          saw_irq;

        rst_n_sys = 1'b0;
        haddr     = '0;
        hwrite    = 1'b0;
        htrans    = apu_pkg::HTRANS_IDLE;
        hready    = 1'b1;
        hwdata    = '0;
        void'($urandom(71));

        apply_reset();

        // RAM write and readback at random word addresses
        err0 = errors;
        for (int i = 0; i < N_RAM; i++) begin
            ram_addr[i] = 16'($urandom) & 16'h7FFC;
            data = $urandom;
            idx = int'(ram_addr[i] >> 2) % `APU_RAM_DEPTH;
            ram_model[idx] = data;
            bus_write(ram_addr[i], data);
        end
        for (int i = 0; i < N_RAM; i++) begin
            idx = int'(ram_addr[i] >> 2) % `APU_RAM_DEPTH;
            bus_read(ram_addr[i], rd);
            check_value("RAM readback", rd, ram_model[idx]);
        end
        finish_test("RAM random write and readback", err0);

        // Unmapped pages answer ERROR and leave the RAM alone
        err0 = errors;
        ram_model[0] = 32'h5A5A_0F0F;
        bus_write(16'h0000, ram_model[0]);
        bus_access(1'b1, 16'h8000, 32'hFFFF_FFFF, 1'b1, rd);
        bus_access(1'b0, 16'hB004, 32'd0, 1'b1, rd);
        bus_read(16'h0000, rd);
        check_value("RAM read after error", rd, ram_model[0]);
        finish_test("Unmapped address error response", err0);

        // Timer count and compare interrupt
        err0 = errors;
        bus_write(timer_addr(apu_pkg::TIMER_COUNT), 32'd0);
        bus_write(timer_addr(apu_pkg::TIMER_CMP), 32'd100);
        bus_write(timer_addr(apu_pkg::TIMER_CTRL), 32'd1);
        last_count = 0;
        saw_irq = 0;
        reads = 0;
        rd = 0;
        while (rd < 120 && reads < 100) begin
            bus_read(timer_addr(apu_pkg::TIMER_COUNT), rd);
            reads++;
            if (rd <= last_count) begin
                $display("[ERROR] %0t: COUNT did not increase (%0d after %0d)",
                         $time, rd, last_count);
                errors++;
            end
            // irq is registered from the same count value that was read
            check_value("irq_timer", {31'd0, irq_timer}, {31'd0, rd >= 100});
            if (irq_timer)
                saw_irq = 1;
            last_count = rd;
        end
        if (!saw_irq) begin
            $display("Timer interrupt never went high");
            errors++;
        end
        bus_write(timer_addr(apu_pkg::TIMER_CTRL), 32'd0);
        repeat (2) @(negedge clk_sys);
        check_value("irq_timer after disable", {31'd0, irq_timer}, 32'd0);
        finish_test("Timer count and interrupt", err0);

        // FIFO fill level, full drop and level interrupt
        err0 = errors;
        bus_write(aout_addr(apu_pkg::AOUT_IRQLEVEL), 32'd1);
        check_value("irq_aout empty", {31'd0, irq_aout}, 32'd1);
        for (int i = 1; i <= 5; i++) begin
            bus_write(aout_addr(apu_pkg::AOUT_FIFO), $urandom);
            lvl = (i > 4) ? 4 : i;
            bus_read(aout_addr(apu_pkg::AOUT_STATUS), rd);
            check_value("STATUS", rd, ((lvl < 4) ? 32'h8 : 32'h0) | 32'(lvl));
            check_value("irq_aout", {31'd0, irq_aout}, {31'd0, lvl <= 1});
        end
        finish_test("FIFO level and interrupt", err0);

        // Unsigned sample 0x4000 plays unchanged with a top byte of 0x40
        err0 = errors;
        apply_reset();
        bus_read(aout_addr(apu_pkg::AOUT_STATUS), rd);
        check_value("STATUS after reset", rd, 32'h8);
        bus_write(aout_addr(apu_pkg::AOUT_CSR), 32'h0);
        bus_write(aout_addr(apu_pkg::AOUT_INTERVAL), 32'd0);
        bus_write(aout_addr(apu_pkg::AOUT_FIFO), 32'h4000);
        bus_write(aout_addr(apu_pkg::AOUT_CSR), 32'h1);
        measure_duty("PWM high cycles, sample 0x4000", 64);
        finish_test("PWM output, unsigned sample", err0);

        // Signed sample 0x0000 plays as 0x8000, then the player stops
        err0 = errors;
        bus_write(aout_addr(apu_pkg::AOUT_CSR), 32'h2);
        // Player leaves PLAY on the edge after enable drops
        @(negedge clk_sys);
        check_value("audio while disabled", {31'd0, audio}, 32'd0);
        bus_write(aout_addr(apu_pkg::AOUT_FIFO), 32'h0000);
        bus_write(aout_addr(apu_pkg::AOUT_CSR), 32'h3);
        measure_duty("PWM high cycles, sample 0x8000", 128);
        bus_write(aout_addr(apu_pkg::AOUT_CSR), 32'h2);
        @(negedge clk_sys);
        high = 0;
        repeat (300) begin
            if (audio)
                high++;
            @(negedge clk_sys);
        end
        check_value("audio high cycles after disable", 32'(high), 32'd0);
        bus_read(aout_addr(apu_pkg::AOUT_CSR), rd);
        check_value("CSR with running clear", rd, 32'h2);
        finish_test("PWM output, signed sample and stop", err0);

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
source/apu_pkg.sv
source/apu_bus_if.sv
source/apu_bus_decoder.sv
source/apu_ram.sv
source/apu_timer.sv
source/apu_aout_regs.sv
source/apu_sample_fifo.sv
source/apu_aout.sv
source/audio_processor.sv
testbench/tb_audio_processor.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        := tb_audio_processor
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
PASS_MSG   := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
